//--- verilog/FpExecTypes.sv
/*
 * Shared definitions for the floating-point execution stage:
 *   sizing and format constants,
 *   the op encoding,
 *   the single-precision word with its raw and field views,
 *   the circular tag range check used for selective flush
 */

package FpExecTypes;

    // Active-list tag
    localparam int TAG_BITS = 4;

    // IEEE single precision
    localparam int EXP_BIAS = 127;

    // 24 mantissa bits plus one so the quotient can be normalized
    localparam int QUO_STEPS = 25;

    typedef logic [TAG_BITS-1:0] FpTag;

    typedef enum logic [2:0] {
        OpMul,
        OpDiv,
        OpMin,
        OpMax,
        OpSgnJ,
        OpSgnJn,
        OpSgnJx
    } FpOp;

    // One word, read as raw bits or as IEEE fields
    typedef union packed {
        logic [31:0] bits;
        struct packed {
            logic        sign;
            logic [7:0]  exponent;
            logic [22:0] mantissa;
        } fields;
    } FpWord;

    // True when tag is in [head, tail) on the circular active list
    // head == tail means an empty range
    function automatic logic inFlushRange(FpTag tag, FpTag head, FpTag tail);
        FpTag offset;
        FpTag span;
        // Distances from head wrap naturally in TAG_BITS
        offset = tag - head;
        span = tail - head;
        return offset < span;
    endfunction

endpackage

//--- verilog/DivCycleCounter.sv
/*
 * Down counter for the divider iterations
 * Loads the step count and flags the final step
 */

module DivCycleCounter import FpExecTypes::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       load,
    output logic [4:0] count,
    output logic       last
);
    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= '0;
        end else if (load) begin
            count <= 5'(QUO_STEPS - 1);
        end else if (count != 5'd0) begin
            count <= count - 1'b1;
        end
    end

    // Final busy cycle
    assign last = count == 5'd1;

endmodule

//--- verilog/DivControl.sv
/*
 * Divider reservation FSM
 *   Idle -> Busy on a ready request, tag of the owner held
 *   Busy -> Done when the step counter runs out
 *   Done -> Idle when the owner takes its result
 * Flush of the held tag or clear returns to Idle
 */

module DivControl import FpExecTypes::*; (
    input  logic clk,
    input  logic rstN,
    input  logic request,
    input  FpTag requestTag,
    input  logic operandsReady,
    input  logic releaseReq,
    input  logic flushValid,
    input  FpTag flushHead,
    input  FpTag flushTail,
    input  logic clear,
    output logic start,
    output logic ownsResult
);
    typedef enum logic [1:0] {
        Idle,
        Busy,
        Done
    } DivState;

    DivState state;
    FpTag    heldTag;
    logic    heldFlushed;
    logic    last;

    DivCycleCounter i_counter (
        .clk  (clk),
        .rstN (rstN),
        .load (start),
        .count(),
        .last (last)
    );

    assign heldFlushed = flushValid && inFlushRange(heldTag, flushHead, flushTail);
    assign start = (state == Idle) && request && operandsReady && !clear;
    // Only the op that reserved the divider may take the quotient
    assign ownsResult = (state == Done) && (heldTag == requestTag);

    always_ff @(posedge clk) begin
        if (!rstN || clear) begin
            state <= Idle;
        end else begin
            case (state)
                Idle: if (start) state <= Busy;
                Busy: begin
                    if (heldFlushed) begin
                        state <= Idle;
                    end else if (last) begin
                        state <= Done;
                    end
                end
                Done: if (heldFlushed || releaseReq) state <= Idle;
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            heldTag <= requestTag;
        end
    end

endmodule

//--- verilog/FpMultiplier.sv
/*
 * Pipelined single-precision multiplier
 *   stage 1: mantissa product with hidden bits, exponent sum
 *   stage 2: normalize on the top product bit, truncate
 *   stage 3: zero, overflow and underflow rules
 * Subnormal inputs count as zero, rounding is toward zero
 */

module FpMultiplier import FpExecTypes::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  advance,
    input  FpWord lhs,
    input  FpWord rhs,
    output FpWord result
);
    logic [47:0]       prodNext;
    logic signed [9:0] expSumNext;
    logic              zeroNext;

    logic              s1Sign;
    logic              s1Zero;
    logic signed [9:0] s1Exp;
    logic [47:0]       s1Prod;

    logic              s2Sign;
    logic              s2Zero;
    logic signed [9:0] s2Exp;
    logic [22:0]       s2Mant;

    assign prodNext = {1'b1, lhs.fields.mantissa} * {1'b1, rhs.fields.mantissa};
    assign expSumNext = $signed({2'b00, lhs.fields.exponent})
                      + $signed({2'b00, rhs.fields.exponent})
                      - 10'(EXP_BIAS);
    // Exponent zero means zero or subnormal, both flushed
    assign zeroNext = (lhs.fields.exponent == 8'd0) || (rhs.fields.exponent == 8'd0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            s1Sign <= 1'b0;
            s1Zero <= 1'b1;
            s1Exp <= '0;
            s1Prod <= '0;
            s2Sign <= 1'b0;
            s2Zero <= 1'b1;
            s2Exp <= '0;
            s2Mant <= '0;
        end else if (advance) begin
            s1Sign <= lhs.fields.sign ^ rhs.fields.sign;
            s1Zero <= zeroNext;
            s1Exp <= expSumNext;
            s1Prod <= prodNext;

            s2Sign <= s1Sign;
            s2Zero <= s1Zero;
            // Product of two 1.x values lies in [1, 4)
            if (s1Prod[47]) begin
                s2Exp <= s1Exp + 10'sd1;
                s2Mant <= s1Prod[46:24];
            end else begin
                s2Exp <= s1Exp;
                s2Mant <= s1Prod[45:23];
            end
        end
    end

    always_comb begin
        result = '0;
        result.fields.sign = s2Sign;
        if (s2Zero || s2Exp <= 0) begin
            // Signed zero, underflow included
            result.fields.exponent = 8'd0;
        end else if (s2Exp >= 255) begin
            result.fields.exponent = 8'hFF;
        end else begin
            result.fields.exponent = s2Exp[7:0];
            result.fields.mantissa = s2Mant;
        end
    end

endmodule

//--- verilog/FpMiscUnit.sv
/*
 * Min, max and sign injection unit
 *   stage 1: sign-magnitude compare in both directions
 *   stage 2: result select, registered
 * Latency matches the multiplier
 */

module FpMiscUnit import FpExecTypes::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  advance,
    input  FpOp   op,
    input  FpWord lhs,
    input  FpWord rhs,
    output FpWord result
);
    FpOp   s1Op;
    FpWord s1Lhs;
    FpWord s1Rhs;
    logic  s1LhsLess;
    logic  s1RhsLess;
    FpWord pick;

    // Sign-magnitude order, -0 sorts below +0
    function automatic logic isLess(FpWord a, FpWord b);
        if (a.fields.sign != b.fields.sign) begin
            return a.fields.sign;
        end
        if (a.fields.sign) begin
            return a.bits[30:0] > b.bits[30:0];
        end
        return a.bits[30:0] < b.bits[30:0];
    endfunction

    always_comb begin
        pick = s1Lhs;
        case (s1Op)
            // ties keep lhs
            OpMin: if (s1RhsLess) pick = s1Rhs;
            OpMax: if (s1LhsLess) pick = s1Rhs;
            OpSgnJ: pick.fields.sign = s1Rhs.fields.sign;
            OpSgnJn: pick.fields.sign = !s1Rhs.fields.sign;
            OpSgnJx: pick.fields.sign = s1Lhs.fields.sign ^ s1Rhs.fields.sign;
            default: pick = s1Lhs;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            s1Op <= OpMin;
            s1Lhs <= '0;
            s1Rhs <= '0;
            s1LhsLess <= 1'b0;
            s1RhsLess <= 1'b0;
            result <= '0;
        end else if (advance) begin
            s1Op <= op;
            s1Lhs <= lhs;
            s1Rhs <= rhs;
            s1LhsLess <= isLess(lhs, rhs);
            s1RhsLess <= isLess(rhs, lhs);
            result <= pick;
        end
    end

endmodule

//--- verilog/FpDivider.sv
/*
 * Iterative single-precision divider
 *   restoring division on 24-bit mantissas, one quotient bit per cycle
 *   first bit is formed on start, QUO_STEPS bits in total
 *   normalize, special zeros, overflow and underflow on the output
 * Rounding is toward zero
 */

module FpDivider import FpExecTypes::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  start,
    input  FpWord dividend,
    input  FpWord divisor,
    output FpWord quotient
);
    logic [24:0]       rem;
    // Sentinel bit marks progress, top bit set once all bits are in
    logic [25:0]       quo;
    logic [23:0]       divMant;
    logic              sign;
    logic signed [9:0] expDiff;
    logic              zeroDivisor;
    logic              zeroDividend;

    logic [25:0]       firstStep;
    logic [25:0]       iterStep;
    logic signed [9:0] normExp;
    logic [22:0]       normMant;

    // One restoring step, returns quotient bit and shifted remainder
    function automatic logic [25:0] restoreStep(logic [24:0] partial, logic [23:0] den);
        logic [24:0] diff;
        logic        take;
        take = partial >= {1'b0, den};
        diff = partial - {1'b0, den};
        return {take, (take ? diff : partial) << 1};
    endfunction

    assign firstStep = restoreStep({2'b01, dividend.fields.mantissa},
                                   {1'b1, divisor.fields.mantissa});
    assign iterStep = restoreStep(rem, divMant);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            quo <= {1'b1, 25'd0};
        end else if (start) begin
            quo <= {24'd0, 1'b1, firstStep[25]};
        end else if (!quo[25]) begin
            quo <= {quo[24:0], iterStep[25]};
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem <= firstStep[24:0];
            divMant <= {1'b1, divisor.fields.mantissa};
            sign <= dividend.fields.sign ^ divisor.fields.sign;
            expDiff <= $signed({2'b00, dividend.fields.exponent})
                     - $signed({2'b00, divisor.fields.exponent})
                     + 10'(EXP_BIAS);
            zeroDivisor <= divisor.fields.exponent == 8'd0;
            zeroDividend <= dividend.fields.exponent == 8'd0;
        end else if (!quo[25]) begin
            rem <= iterStep[24:0];
        end
    end

    // Quotient of two 1.x values lies in (0.5, 2)
    assign normExp = quo[24] ? expDiff : expDiff - 10'sd1;
    assign normMant = quo[24] ? quo[23:1] : quo[22:0];

    always_comb begin
        quotient = '0;
        quotient.fields.sign = sign;
        if (zeroDivisor) begin
            quotient.fields.exponent = 8'hFF;
        end else if (zeroDividend || normExp <= 0) begin
            quotient.fields.exponent = 8'd0;
        end else if (normExp >= 255) begin
            quotient.fields.exponent = 8'hFF;
        end else begin
            quotient.fields.exponent = normExp[7:0];
            quotient.fields.mantissa = normMant;
        end
    end

endmodule

//--- verilog/FpExecStage.sv
/*
 * Floating-point execution stage, one lane, three stages deep
 *   stage registers with selective flush, clear and stall
 *   operand readiness and divider ownership at stage 0
 *   result or replay at stage 2, divider release
 *   multiplier, misc unit, divider and its control
 */

module FpExecStage import FpExecTypes::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  stall,
    input  logic  clear,
    input  logic  issueValid,
    input  FpOp   issueOp,
    input  FpTag  issueTag,
    input  FpWord opA,
    input  FpWord opB,
    input  logic  opAReady,
    input  logic  opBReady,
    input  logic  flushValid,
    input  FpTag  flushHead,
    input  FpTag  flushTail,
    output logic  resultValid,
    output FpWord resultData,
    output FpTag  resultTag,
    output logic  replayValid,
    output FpOp   replayOp,
    output FpTag  replayTag
);
    // Stage registers, index 0 is the issue boundary
    logic [2:0] stageValid;
    logic [2:0] stageRegValid;
    FpOp        stageOp [3];
    FpTag       stageTag [3];
    FpWord      stageOpA;
    FpWord      stageOpB;

    logic [2:0] flushHit;
    logic       readyAt0;
    logic       outValid;

    logic       divRequest;
    logic       divStart;
    logic       divOwns;
    logic       divRelease;

    FpWord      mulResult;
    FpWord      miscResult;
    FpWord      divQuotient;

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            flushHit[i] = flushValid && inFlushRange(stageTag[i], flushHead, flushTail);
        end
    end

    // A div op may only finish with a quotient it owns
    assign readyAt0 = stageRegValid[0] && (stageOp[0] != OpDiv || divOwns);
    assign divRequest = stageValid[0] && (stageOp[0] == OpDiv) && !flushHit[0];

    always_ff @(posedge clk) begin
        if (!rstN || clear) begin
            stageValid <= '0;
            stageRegValid <= '0;
        end else if (stall) begin
            // Frozen, but flushes still land
            stageValid <= stageValid & ~flushHit;
        end else begin
            stageValid <= {stageValid[1] & ~flushHit[1], stageValid[0] & ~flushHit[0], issueValid};
            stageRegValid <= {stageRegValid[1], readyAt0, opAReady & opBReady};
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            stageOp[0] <= issueOp;
            stageTag[0] <= issueTag;
            stageOpA <= opA;
            stageOpB <= opB;
            for (int i = 1; i < 3; i++) begin
                stageOp[i] <= stageOp[i-1];
                stageTag[i] <= stageTag[i-1];
            end
        end
    end

    FpMultiplier i_multiplier (
        .clk    (clk),
        .rstN   (rstN),
        .advance(!stall),
        .lhs    (stageOpA),
        .rhs    (stageOpB),
        .result (mulResult)
    );

    FpMiscUnit i_miscUnit (
        .clk    (clk),
        .rstN   (rstN),
        .advance(!stall),
        .op     (stageOp[0]),
        .lhs    (stageOpA),
        .rhs    (stageOpB),
        .result (miscResult)
    );

    DivControl i_divControl (
        .clk          (clk),
        .rstN         (rstN),
        .request      (divRequest),
        .requestTag   (stageTag[0]),
        .operandsReady(stageRegValid[0]),
        .releaseReq   (divRelease),
        .flushValid   (flushValid),
        .flushHead    (flushHead),
        .flushTail    (flushTail),
        .clear        (clear),
        .start        (divStart),
        .ownsResult   (divOwns)
    );

    // keeps iterating through a stall
    FpDivider i_divider (
        .clk     (clk),
        .rstN    (rstN),
        .start   (divStart),
        .dividend(stageOpA),
        .divisor (stageOpB),
        .quotient(divQuotient)
    );

    assign outValid = stageValid[2] && !flushHit[2] && !stall && !clear;
    assign resultValid = outValid && stageRegValid[2];
    assign replayValid = outValid && !stageRegValid[2];
    assign resultTag = stageTag[2];
    assign replayOp = stageOp[2];
    assign replayTag = stageTag[2];

    // Owner leaving with its quotient frees the divider
    assign divRelease = resultValid && (stageOp[2] == OpDiv);

    always_comb begin
        case (stageOp[2])
            OpMul: resultData = mulResult;
            OpDiv: resultData = divQuotient;
            default: resultData = miscResult;
        endcase
    end

endmodule

//--- testbench/FpExecRef.svh
/*
 * Reference model for the execution stage
 *   single word to double and back, truncating toward zero
 *   expected results for mul, div, min, max and sign injection
 *   circular tag range for selective flush
 */

`ifndef FP_EXEC_REF_SVH
`define FP_EXEC_REF_SVH

// Normal or zero single word as a double
function automatic real wordToReal(FpWord w);
    logic [10:0] dblExp;
    if (w.fields.exponent == 8'd0) begin
        return $bitstoreal({w.fields.sign, 63'd0});
    end
    dblExp = 11'(int'(w.fields.exponent) - EXP_BIAS + 1023);
    return $bitstoreal({w.fields.sign, dblExp, w.fields.mantissa, 29'd0});
endfunction

// Double to single, extra mantissa bits chopped off
function automatic FpWord realToWord(real r);
    logic [63:0] d;
    int          e;
    FpWord       w;
    d = $realtobits(r);
    e = int'(d[62:52]) - 1023 + EXP_BIAS;
    w = '0;
    w.fields.sign = d[63];
    if (e >= 255) begin
        w.fields.exponent = 8'hFF;
    end else if (e > 0) begin
        w.fields.exponent = 8'(e);
        w.fields.mantissa = d[51:29];
    end
    return w;
endfunction

// Numeric order, with -0 below +0
function automatic logic refLess(FpWord a, FpWord b);
    real ra;
    real rb;
    ra = wordToReal(a);
    rb = wordToReal(b);
    if (ra == rb) begin
        return a.fields.sign && !b.fields.sign;
    end
    return ra < rb;
endfunction

function automatic FpWord refResult(FpOp op, FpWord a, FpWord b);
    FpWord w;
    w = a;
    case (op)
        OpMul: w = realToWord(wordToReal(a) * wordToReal(b));
        OpDiv: begin
            if (b.fields.exponent == 8'd0) begin
                // Signed infinity
                w = '0;
                w.fields.sign = a.fields.sign ^ b.fields.sign;
                w.fields.exponent = 8'hFF;
            end else begin
                w = realToWord(wordToReal(a) / wordToReal(b));
            end
        end
        OpMin: if (refLess(b, a)) w = b;
        OpMax: if (refLess(a, b)) w = b;
        OpSgnJ: w.fields.sign = b.fields.sign;
        OpSgnJn: w.fields.sign = !b.fields.sign;
        OpSgnJx: w.fields.sign = a.fields.sign ^ b.fields.sign;
        default: w = a;
    endcase
    return w;
endfunction

// Walk the active list from head, stop at tail
function automatic logic refInRange(FpTag tag, FpTag head, FpTag tail);
    FpTag t;
    t = head;
    while (t != tail) begin
        if (t == tag) begin
            return 1'b1;
        end
        t = t + 1'b1;
    end
    return 1'b0;
endfunction

`endif

//--- testbench/FpExecTb.sv
/*
 * Testbench for the floating-point execution stage
 *   clock, reset and input driving
 *   scoreboard of in-flight ops with replay and reissue
 *   random mul and misc ops, operands not ready, div ownership
 *   selective flush, stall and clear
 */

module FpExecTb import FpExecTypes::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    `include "FpExecRef.svh"

    typedef struct {
        FpOp   op;
        FpTag  tag;
        FpWord a;
        FpWord b;
        logic  ready;
        int    issueAt;
    } IssueRec;

    logic  clk;
    logic  rstN;
    logic  stall;
    logic  clear;
    logic  issueValid;
    FpOp   issueOp;
    FpTag  issueTag;
    FpWord opA;
    FpWord opB;
    logic  opAReady;
    logic  opBReady;
    logic  flushValid;
    FpTag  flushHead;
    FpTag  flushTail;
    logic  resultValid;
    FpWord resultData;
    FpTag  resultTag;
    logic  replayValid;
    FpOp   replayOp;
    FpTag  replayTag;

    IssueRec inFlight[$];
    IssueRec retryQ[$];
    int      advCount = 0;
    FpTag    nextTag = '0;

    FpExecStage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Stages move only on edges without stall
    always @(posedge clk) begin
        if (!stall) begin
            advCount <= advCount + 1;
        end
    end

    task automatic stopWithFailure(string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic checkWord(string name, FpWord got, FpWord want);
        if (got !== want) begin
            stopWithFailure($sformatf("Fail %s: got %h, expected %h", name, got.bits, want.bits));
        end
    endtask

    task automatic checkTag(string name, FpTag got, FpTag want);
        if (got !== want) begin
            stopWithFailure($sformatf("Fail %s: got %h, expected %h", name, got, want));
        end
    endtask

    task automatic checkOp(string name, FpOp got, FpOp want);
        if (got !== want) begin
            stopWithFailure($sformatf("Fail %s: got %h, expected %h", name, got, want));
        end
    endtask

    task automatic nextSlot();
        @(posedge clk);
        #10;
    endtask

    task automatic issueOne(FpOp op, FpTag tag, FpWord a, FpWord b, logic readyA, logic readyB);
        IssueRec rec;
        rec.op = op;
        rec.tag = tag;
        rec.a = a;
        rec.b = b;
        rec.ready = readyA && readyB;
        rec.issueAt = advCount + 1;
        inFlight.push_back(rec);
        issueValid = 1'b1;
        issueOp = op;
        issueTag = tag;
        opA = a;
        opB = b;
        opAReady = readyA;
        opBReady = readyB;
        nextSlot();
        issueValid = 1'b0;
    endtask

    task automatic issueNew(FpOp op, FpWord a, FpWord b, logic readyA, logic readyB);
        issueOne(op, nextTag, a, b, readyA, readyB);
        nextTag = nextTag + 1'b1;
    endtask

    // Reissue replays until nothing is pending
    task automatic drainAll(int limit);
        IssueRec rec;
        int      waited;
        waited = 0;
        while (inFlight.size() != 0 || retryQ.size() != 0) begin
            if (waited >= limit) begin
                stopWithFailure($sformatf("Timeout: ops still pending after %0d cycles", limit));
            end
            if (retryQ.size() != 0) begin
                rec = retryQ.pop_front();
                issueOne(rec.op, rec.tag, rec.a, rec.b, 1'b1, 1'b1);
            end else begin
                nextSlot();
            end
            waited++;
        end
    endtask

    task automatic waitPipeEmpty(int limit);
        int waited;
        waited = 0;
        while (inFlight.size() != 0) begin
            if (waited >= limit) begin
                stopWithFailure("Timeout: the pipeline did not empty");
            end
            nextSlot();
            waited++;
        end
    endtask

    task automatic flushTags(FpTag head, FpTag tail);
        flushValid = 1'b1;
        flushHead = head;
        flushTail = tail;
        for (int i = inFlight.size() - 1; i >= 0; i--) begin
            if (refInRange(inFlight[i].tag, head, tail)) inFlight.delete(i);
        end
        for (int i = retryQ.size() - 1; i >= 0; i--) begin
            if (refInRange(retryQ[i].tag, head, tail)) retryQ.delete(i);
        end
        nextSlot();
        flushValid = 1'b0;
    endtask

    task automatic clearAll();
        clear = 1'b1;
        inFlight.delete();
        retryQ.delete();
        nextSlot();
        clear = 1'b0;
    endtask

    task automatic stallFor(int cycles);
        stall = 1'b1;
        repeat (cycles) nextSlot();
        stall = 1'b0;
    endtask

    // Normal operands with exponents far from overflow and underflow
    function automatic FpWord randomWord();
        FpWord w;
        w.fields.sign = 1'($urandom);
        w.fields.exponent = 8'(110 + $urandom % 36);
        w.fields.mantissa = 23'($urandom);
        return w;
    endfunction

    function automatic FpOp randomOp();
        case ($urandom % 6)
            0: return OpMul;
            1: return OpMin;
            2: return OpMax;
            3: return OpSgnJ;
            4: return OpSgnJn;
            default: return OpSgnJx;
        endcase
    endfunction

    // Outputs are stable at the falling edge
    always @(negedge clk) begin : compare
        IssueRec rec;
        if (rstN && (resultValid || replayValid)) begin
            if (stall) stopWithFailure("An output was valid while the stage was stalled");
            if (resultValid && replayValid) stopWithFailure("Result and replay came together");
            if (inFlight.size() == 0) stopWithFailure("An output came with no op in flight");
            rec = inFlight.pop_front();
            if (advCount != rec.issueAt + 2) begin
                stopWithFailure($sformatf("Op with tag %h came out at advance %0d, not %0d",
                                          rec.tag, advCount, rec.issueAt + 2));
            end
            if (resultValid) begin
                if (!rec.ready) stopWithFailure("An op without ready operands gave a result");
                checkTag("resultTag", resultTag, rec.tag);
                checkWord("resultData", resultData, refResult(rec.op, rec.a, rec.b));
            end else begin
                if (rec.ready && rec.op != OpDiv) stopWithFailure("A ready non-div op replayed");
                checkTag("replayTag", replayTag, rec.tag);
                checkOp("replayOp", replayOp, rec.op);
                retryQ.push_back(rec);
            end
        end
    end

    initial begin
        FpWord posZero;
        FpWord negZero;
        FpWord x;
        FpTag  divTag;
        FpTag  divTail;
        void'($urandom(58851));
        posZero = 32'h0000_0000;
        negZero = 32'h8000_0000;
        rstN = 1'b0;
        stall = 1'b0;
        clear = 1'b0;
        issueValid = 1'b0;
        issueOp = OpMul;
        issueTag = '0;
        opA = '0;
        opB = '0;
        opAReady = 1'b0;
        opBReady = 1'b0;
        flushValid = 1'b0;
        flushHead = '0;
        flushTail = '0;
        repeat (4) @(posedge clk);
        #10;
        rstN = 1'b1;
        if (resultValid || replayValid) stopWithFailure("Outputs were valid after reset");

        // Random mul and misc ops, then zero and tie cases
        for (int n = 0; n < 48; n++) begin
            issueNew(randomOp(), randomWord(), randomWord(), 1'b1, 1'b1);
        end
        x = randomWord();
        issueNew(OpMin, posZero, negZero, 1'b1, 1'b1);
        issueNew(OpMax, negZero, posZero, 1'b1, 1'b1);
        issueNew(OpMin, x, x, 1'b1, 1'b1);
        issueNew(OpMul, x, negZero, 1'b1, 1'b1);
        drainAll(60);

        // Operands not ready
        issueNew(OpMul, randomWord(), randomWord(), 1'b0, 1'b1);
        issueNew(OpSgnJx, randomWord(), randomWord(), 1'b1, 1'b0);
        issueNew(OpMax, randomWord(), randomWord(), 1'b0, 1'b0);
        drainAll(30);

        // Div, alone, back to back, and with zero operands
        for (int n = 0; n < 3; n++) begin
            issueNew(OpDiv, randomWord(), randomWord(), 1'b1, 1'b1);
            drainAll(120);
        end
        issueNew(OpDiv, randomWord(), randomWord(), 1'b1, 1'b1);
        issueNew(OpDiv, randomWord(), randomWord(), 1'b1, 1'b1);
        drainAll(250);
        issueNew(OpDiv, randomWord(), negZero, 1'b1, 1'b1);
        drainAll(120);
        issueNew(OpDiv, negZero, randomWord(), 1'b1, 1'b1);
        drainAll(120);

        // Wrapping flush range catches 15 and 0
        nextTag = 4'd14;
        for (int n = 0; n < 4; n++) begin
            issueNew(OpMul, randomWord(), randomWord(), 1'b1, 1'b1);
        end
        flushTags(4'd15, 4'd1);
        drainAll(20);
        nextTag = 4'd4;
        for (int n = 0; n < 3; n++) begin
            issueNew(OpSgnJn, randomWord(), randomWord(), 1'b1, 1'b1);
        end
        flushTags(4'd5, 4'd7);
        drainAll(20);

        // Flushing the owner of the divider frees it
        divTag = nextTag;
        divTail = divTag + 1'b1;
        issueNew(OpDiv, randomWord(), randomWord(), 1'b1, 1'b1);
        waitPipeEmpty(10);
        flushTags(divTag, divTail);
        issueNew(OpDiv, randomWord(), randomWord(), 1'b1, 1'b1);
        drainAll(120);

        // Stall with a full pipeline, then in the middle of issue
        for (int n = 0; n < 3; n++) begin
            issueNew(randomOp(), randomWord(), randomWord(), 1'b1, 1'b1);
        end
        stallFor(5);
        issueNew(randomOp(), randomWord(), randomWord(), 1'b1, 1'b1);
        stallFor(3);
        issueNew(randomOp(), randomWord(), randomWord(), 1'b1, 1'b1);
        drainAll(20);

        // Clear with the divider reserved
        issueNew(OpDiv, randomWord(), randomWord(), 1'b1, 1'b1);
        issueNew(OpMul, randomWord(), randomWord(), 1'b1, 1'b1);
        issueNew(OpMax, randomWord(), randomWord(), 1'b1, 1'b1);
        clearAll();
        issueNew(OpDiv, randomWord(), randomWord(), 1'b1, 1'b1);
        issueNew(OpMul, randomWord(), randomWord(), 1'b1, 1'b1);
        drainAll(120);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- list.f
+incdir+testbench
verilog/FpExecTypes.sv
verilog/DivCycleCounter.sv
verilog/DivControl.sv
verilog/FpMultiplier.sv
verilog/FpMiscUnit.sv
verilog/FpDivider.sv
verilog/FpExecStage.sv
testbench/FpExecTb.sv

//--- run.sh
#!/bin/sh
# Build and run the execution stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f list.f --top-module FpExecTb -Mdir obj_dir
out=$(./obj_dir/VFpExecTb 2>&1) || true
echo "$out"
if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
